// File: hw/cpu_core.sv
/* Top of the integer core: fetch, decode, execute and result stages between the
   instruction memory port, the stall/flush controls and the commit port */
`timescale 1ns/1ps

module cpu_core import cpu_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic [WORD_W-1:0] insn,        // Instruction memory data
    input  logic              data_rdy,    // Instruction memory ready
    input  logic              stall,       // Memory stage freeze
    input  logic              flush,       // Redirect pulse
    input  logic [WORD_W-1:0] new_pc,
    output logic [WORD_W-1:0] fetch_addr,
    output commit_t           wb,
    output logic [WORD_W-1:0] retired
);

    fetch_t            if_bus;
    decode_t           id_bus;
    commit_t           ex_bus;
    logic              br_taken;
    logic [WORD_W-1:0] br_addr;
    logic [REG_W-1:0]  rd_addr_a;
    logic [REG_W-1:0]  rd_addr_b;
    logic [WORD_W-1:0] rd_data_a;
    logic [WORD_W-1:0] rd_data_b;

    fetch_stage fetch_stage_i (
        .clk, .rst, .insn, .data_rdy, .stall, .flush, .new_pc,
        .br_taken, .br_addr,
        .fetch_addr,
        .if_out     (if_bus)
    );

    decode_stage decode_stage_i (
        .clk, .rst,
        .if_in      (if_bus),
        .stall, .flush, .br_taken,
        .rd_data_a, .rd_data_b, .rd_addr_a, .rd_addr_b,
        .id_out     (id_bus)
    );

    execute_stage execute_stage_i (
        .clk, .rst,
        .id_in      (id_bus),
        .stall, .flush,
        .ex_out     (ex_bus),              // Also forwarding source
        .br_taken, .br_addr
    );

    result_stage result_stage_i (
        .clk, .rst,
        .ex_in      (ex_bus),
        .stall,
        .rd_addr_a, .rd_addr_b, .rd_data_a, .rd_data_b,
        .wb, .retired
    );

endmodule

// File: hw/cpu_pkg.sv
/* Instruction-set constants, instruction field views and pipeline stage bundles
   shared by every stage of the four-step integer core */
package cpu_pkg;

    localparam int WORD_W = 32;                      // Data and address width
    localparam int REG_N  = 16;                      // Register file depth
    localparam int REG_W  = $clog2(REG_N);           // Register index width
    localparam logic [WORD_W-1:0] RESET_PC = '0;     // Fetch start address

    // 6-bit opcodes
    localparam logic [5:0] OP_RTYPE = 6'h00;         // ALU register form
    localparam logic [5:0] OP_ADDI  = 6'h01;         // rd = rs + sext(imm)
    localparam logic [5:0] OP_BEQ   = 6'h02;         // Branch if rd == rs
    localparam logic [5:0] OP_BNE   = 6'h03;         // Branch if rd != rs

    // R-type function codes
    localparam logic [5:0] FN_ADD = 6'h00;           // Zero so NOP is an add
    localparam logic [5:0] FN_SUB = 6'h01;
    localparam logic [5:0] FN_AND = 6'h02;
    localparam logic [5:0] FN_OR  = 6'h03;
    localparam logic [5:0] FN_XOR = 6'h04;
    localparam logic [5:0] FN_SLT = 6'h05;           // Signed compare

    localparam logic [WORD_W-1:0] NOP_INSN = '0;     // add r0, r0, r0

    typedef struct packed {
        logic [5:0]       opcode;
        logic [REG_W-1:0] rd;
        logic [REG_W-1:0] rs;
        logic [REG_W-1:0] rt;
        logic [7:0]       unused;
        logic [5:0]       funct;
    } insn_r_t;

    typedef struct packed {
        logic [5:0]       opcode;
        logic [REG_W-1:0] rd;                        // Also second branch operand
        logic [REG_W-1:0] rs;
        logic [1:0]       pad;
        logic [15:0]      imm;                       // Word offset on branches
    } insn_i_t;

    typedef union packed {
        insn_r_t r;
        insn_i_t i;
    } insn_u;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT
    } alu_op_e;

    typedef struct packed {
        logic              valid;
        logic [WORD_W-1:0] pc;
        logic [WORD_W-1:0] insn;
    } fetch_t;

    typedef struct packed {
        logic              valid;
        logic [WORD_W-1:0] pc;
        alu_op_e           alu_op;
        logic              is_branch;
        logic              branch_ne;
        logic              wen;                      // Cleared for rd == 0
        logic [REG_W-1:0]  rd;
        logic [REG_W-1:0]  rs;                       // Source of op_a
        logic [REG_W-1:0]  rt;                       // Source of op_b, 0 for ADDI
        logic [WORD_W-1:0] op_a;
        logic [WORD_W-1:0] op_b;
        logic [WORD_W-1:0] imm_ext;
    } decode_t;

    typedef struct packed {
        logic              valid;                    // Register write pending
        logic [REG_W-1:0]  rd;
        logic [WORD_W-1:0] data;
    } commit_t;

endpackage

// File: hw/decode_stage.sv
/* Splits the fetched word, reads both source registers and loads the
   decode/execute register; killed by flush or a taken branch */
`timescale 1ns/1ps

module decode_stage import cpu_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  fetch_t            if_in,      // From fetch register
    input  logic              stall,
    input  logic              flush,
    input  logic              br_taken,   // Entry in if_in is wrong-path
    input  logic [WORD_W-1:0] rd_data_a,  // Register file port A
    input  logic [WORD_W-1:0] rd_data_b,  // Register file port B
    output logic [REG_W-1:0]  rd_addr_a,
    output logic [REG_W-1:0]  rd_addr_b,
    output decode_t           id_out      // To execute
);

    insn_u             iw;                // One word in both R and I views
    alu_op_e           alu_op;
    logic              wen;
    logic              is_branch;
    logic              branch_ne;
    logic              use_imm;
    logic [WORD_W-1:0] imm_ext;
    decode_t           id_next;

    assign iw      = if_in.insn;
    assign imm_ext = {{(WORD_W-16){iw.i.imm[15]}}, iw.i.imm};

    // Control decode; unknown codes fall through as a NOP
    always_comb begin
        alu_op    = ALU_ADD;
        wen       = 1'b0;
        is_branch = 1'b0;
        branch_ne = 1'b0;
        use_imm   = 1'b0;
        rd_addr_b = '0;
        case (iw.r.opcode)
            OP_RTYPE: begin
                rd_addr_b = iw.r.rt;
                wen       = 1'b1;
                case (iw.r.funct)
                    FN_ADD:  alu_op = ALU_ADD;
                    FN_SUB:  alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_SLT:  alu_op = ALU_SLT;
                    default: wen    = 1'b0;    // Bad funct is a NOP
                endcase
            end
            OP_ADDI: begin
                wen     = 1'b1;
                use_imm = 1'b1;                // op_b is the immediate
            end
            OP_BEQ, OP_BNE: begin
                is_branch = 1'b1;
                branch_ne = (iw.i.opcode == OP_BNE);
                rd_addr_b = iw.i.rd;           // rd field is a source here
            end
            default: ;
        endcase
        if (iw.r.rd == '0) begin
            wen = 1'b0;                        // r0 is never written
        end
    end

    assign rd_addr_a = iw.r.rs;

    always_comb begin
        id_next           = '0;
        id_next.valid     = if_in.valid && !flush && !br_taken;
        id_next.pc        = if_in.pc;
        id_next.alu_op    = alu_op;
        id_next.is_branch = is_branch;
        id_next.branch_ne = branch_ne;
        id_next.wen       = wen;
        id_next.rd        = iw.r.rd;
        id_next.rs        = rd_addr_a;
        id_next.rt        = rd_addr_b;         // 0 for ADDI, so never forwarded
        id_next.op_a      = rd_data_a;
        id_next.op_b      = use_imm ? imm_ext : rd_data_b;
        id_next.imm_ext   = imm_ext;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            id_out.valid <= 1'b0;
        end else if (!stall) begin
            id_out <= id_next;
        end
    end

endmodule

// File: hw/execute_stage.sv
/* Forwards from the commit register, runs the ALU, resolves branches and loads
   the execute/result register that feeds the register file */
`timescale 1ns/1ps

module execute_stage import cpu_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  decode_t           id_in,      // From decode register
    input  logic              stall,
    input  logic              flush,
    output commit_t           ex_out,     // Execute/result register
    output logic              br_taken,   // Redirect fetch, kill decode
    output logic [WORD_W-1:0] br_addr
);

    logic              fwd_a;
    logic              fwd_b;
    logic [WORD_W-1:0] a;
    logic [WORD_W-1:0] b;
    logic [WORD_W-1:0] alu_res;
    logic              br_cond;

    // Older result still sitting in the commit register
    assign fwd_a = ex_out.valid && (ex_out.rd == id_in.rs) && (id_in.rs != '0);
    assign fwd_b = ex_out.valid && (ex_out.rd == id_in.rt) && (id_in.rt != '0);

    assign a = fwd_a ? ex_out.data : id_in.op_a;
    assign b = fwd_b ? ex_out.data : id_in.op_b;

    always_comb begin
        case (id_in.alu_op)
            ALU_ADD: alu_res = a + b;
            ALU_SUB: alu_res = a - b;
            ALU_AND: alu_res = a & b;
            ALU_OR:  alu_res = a | b;
            ALU_XOR: alu_res = a ^ b;
            ALU_SLT: alu_res = {{(WORD_W-1){1'b0}}, $signed(a) < $signed(b)};
            default: alu_res = a + b;
        endcase
    end

    // Branch compares rs (a) with the rd-field register (b)
    assign br_cond  = id_in.branch_ne ? (a != b) : (a == b);
    assign br_taken = id_in.valid && id_in.is_branch && br_cond;
    assign br_addr  = id_in.pc + WORD_W'(4) + {id_in.imm_ext[WORD_W-3:0], 2'b00};

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_out.valid <= 1'b0;
        end else if (!stall) begin
            ex_out.valid <= id_in.valid && id_in.wen && !flush;  // Branches have no wen
            ex_out.rd    <= id_in.rd;
            ex_out.data  <= alu_res;
        end
    end

    // Taken branch needs a live entry, and decode must drop its follower
    a_branch_kills: assert property (
        @(posedge clk) disable iff (rst)
        (br_taken && !stall) |-> id_in.valid ##1 !id_in.valid
    ) else $error("taken branch without valid entry or follower not killed");

endmodule

// File: hw/fetch_stage.sv
/* Program counter and fetch/decode register; accepts a word when memory is ready
   and takes flush and branch redirects ahead of the sequential advance */
`timescale 1ns/1ps

module fetch_stage import cpu_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic [WORD_W-1:0] insn,        // Word at fetch_addr, same cycle
    input  logic              data_rdy,    // Memory has the word
    input  logic              stall,       // Freeze from memory stage
    input  logic              flush,       // Redirect pulse
    input  logic [WORD_W-1:0] new_pc,      // Flush target
    input  logic              br_taken,    // Resolved in execute
    input  logic [WORD_W-1:0] br_addr,     // Branch target
    output logic [WORD_W-1:0] fetch_addr,  // To instruction memory
    output fetch_t            if_out       // To decode
);

    localparam logic [WORD_W-1:0] STEP = WORD_W'(4);   // One word

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_addr <= RESET_PC;
            if_out     <= '{valid: 1'b0, pc: RESET_PC, insn: NOP_INSN};
        end else if (!stall) begin                // Stall holds everything
            if (flush) begin
                fetch_addr   <= new_pc;           // External redirect wins
                if_out.valid <= 1'b0;
                if_out.insn  <= NOP_INSN;
            end else if (br_taken) begin
                fetch_addr   <= br_addr;          // Drop the wrong-path word
                if_out.valid <= 1'b0;
                if_out.insn  <= NOP_INSN;
            end else if (data_rdy) begin
                fetch_addr <= fetch_addr + STEP;
                if_out     <= '{valid: 1'b1, pc: fetch_addr, insn: insn};
            end else begin
                if_out.valid <= 1'b0;             // Bubble while memory is busy
            end
        end
    end

    // Redirect targets come from other blocks; all of them must stay word aligned
    a_fetch_aligned: assert property (
        @(posedge clk) disable iff (rst) fetch_addr[1:0] == 2'b00
    ) else $error("fetch_addr not word aligned: %h", fetch_addr);

endmodule

// File: hw/result_stage.sv
/* Register file with same-cycle write bypass, the qualified commit port
   and a count of retired register writes */
`timescale 1ns/1ps

module result_stage import cpu_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  commit_t           ex_in,      // Execute/result register
    input  logic              stall,      // Blocks the write
    input  logic [REG_W-1:0]  rd_addr_a,
    input  logic [REG_W-1:0]  rd_addr_b,
    output logic [WORD_W-1:0] rd_data_a,
    output logic [WORD_W-1:0] rd_data_b,
    output commit_t           wb,         // Commit port
    output logic [WORD_W-1:0] retired     // Commits since reset
);

    logic [WORD_W-1:0] regs [REG_N];     // Entry 0 is never written

    // Commit is the register contents, held back during a freeze
    assign wb.valid = ex_in.valid && !stall;
    assign wb.rd    = ex_in.rd;
    assign wb.data  = ex_in.data;

    function automatic logic [WORD_W-1:0] read_port(input logic [REG_W-1:0] addr);
        logic [WORD_W-1:0] val;
        if (addr == '0) begin
            val = '0;                          // r0 reads zero
        end else if (wb.valid && wb.rd == addr) begin
            val = wb.data;                     // Write bypass
        end else begin
            val = regs[addr];
        end
        return val;
    endfunction

    assign rd_data_a = read_port(rd_addr_a);
    assign rd_data_b = read_port(rd_addr_b);

    always_ff @(posedge clk) begin
        if (wb.valid) begin
            regs[wb.rd] <= wb.data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            retired <= '0;
        end else if (wb.valid) begin
            retired <= retired + 1'b1;
        end
    end

    // Decode clears wen for rd 0, so nothing aimed at r0 may reach here
    a_no_r0_commit: assert property (
        @(posedge clk) disable iff (rst) wb.valid |-> (wb.rd != '0)
    ) else $error("commit to r0 with wen set");

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build the core and its testbench with Verilator, run it, and check the result
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
    --top-module cpu_core_tb -o Vcpu_core_tb

output=$(./obj_dir/Vcpu_core_tb 2>&1 || true)
echo "$output"

if grep -qx "Test passed" <<< "$output"; then
    exit 0
else
    exit 1
fi

// File: tb/cpu_core_tb.sv
/* Testbench for the integer core. Flushes into each program of the table, with and
   without random back-pressure, and checks every commit, the halt loop and retired */
`timescale 1ns/1ps

module cpu_core_tb import cpu_pkg::*; ();

    localparam int MEM_WORDS  = 64;
    localparam int CASE_N     = 6;
    localparam int EXP_N      = 24;                 // Expected commits of programs A, B, C
    localparam int HALT_CHECK = 16;                 // Cycles watched in the halt loop
    localparam logic [31:0] SEED = 32'hd772_d78c;

    typedef struct packed {
        logic [WORD_W-1:0] start;                   // Flush target
        logic [WORD_W-1:0] halt;                    // Branch-to-self address
        logic [31:0]       stall_pct;
        logic [31:0]       idle_pct;                // Percent of cycles with data_rdy low
        logic [31:0]       first;                   // Index into exp_tab
        logic [31:0]       count;
    } case_t;

    typedef struct packed {
        logic [REG_W-1:0]  rd;
        logic [WORD_W-1:0] data;
    } exp_t;

    logic              clk      = 1'b0;
    logic              rst      = 1'b1;
    logic [WORD_W-1:0] insn;
    logic              data_rdy = 1'b1;
    logic              stall    = 1'b0;
    logic              flush    = 1'b0;
    logic [WORD_W-1:0] new_pc   = '0;
    logic [WORD_W-1:0] fetch_addr;
    commit_t           wb;
    logic [WORD_W-1:0] retired;

    logic [WORD_W-1:0] imem [MEM_WORDS];
    case_t             cases [CASE_N];
    exp_t              exp_tab [EXP_N];
    exp_t              order [2*EXP_N];             // Commit sequence of the whole run
    int                allowed   = 0;               // Commits expected so far
    int                seen      = 0;               // Commits observed since reset
    int                cycles    = 0;
    int                limit     = 0;
    logic              quiet     = 1'b1;            // Forces clean stall/ready
    int unsigned       stall_pct = 0;
    int unsigned       idle_pct  = 0;

    always #4 clk = ~clk;                           // 8 ns period

    cpu_core cpu_core_i (
        .clk, .rst, .insn, .data_rdy, .stall, .flush, .new_pc,
        .fetch_addr, .wb, .retired
    );

    assign insn = imem[fetch_addr[7:2]];            // Same-cycle word memory

    function automatic logic [31:0] rtype(input logic [5:0] funct, input int rd, rs, rt);
        return {OP_RTYPE, rd[3:0], rs[3:0], rt[3:0], 8'h00, funct};
    endfunction

    function automatic logic [31:0] itype(input logic [5:0] op, input int rd, rs, imm);
        return {op, rd[3:0], rs[3:0], 2'b00, imm[15:0]};   // Branches compare rs with rd
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        fail_run($sformatf("mismatch at %0t: %s expected %h, got %h",
                           $time, name, expected, actual));
    endtask

    task automatic load_program();
        for (int w = 0; w < MEM_WORDS; w++) begin
            imem[w] = itype(OP_ADDI, 15, 0, w);     // Stray fetch commits to r15
        end
        imem[0]  = itype(OP_BEQ, 0, 0, -1);         // Parking loop after reset
        // Program A is a dependent ALU chain
        imem[4]  = itype(OP_ADDI, 1, 0, 5);
        imem[5]  = itype(OP_ADDI, 2, 1, -3);
        imem[6]  = rtype(FN_ADD, 3, 1, 2);
        imem[7]  = rtype(FN_SUB, 4, 2, 3);
        imem[8]  = rtype(FN_AND, 5, 4, 3);
        imem[9]  = rtype(FN_OR,  6, 5, 4);
        imem[10] = rtype(FN_XOR, 7, 6, 1);
        imem[11] = rtype(FN_SLT, 8, 4, 5);
        imem[12] = rtype(FN_SLT, 9, 5, 4);
        imem[13] = itype(OP_ADDI, 10, 8, 32'h7fff);
        imem[14] = itype(OP_ADDI, 11, 10, -32768);  // Negative immediate extremes
        imem[15] = itype(OP_BEQ, 0, 0, -1);
        // Program B has branches and a count-down loop
        imem[16] = itype(OP_ADDI, 1, 0, 1);
        imem[17] = itype(OP_ADDI, 2, 0, 1);
        imem[18] = itype(OP_BEQ, 2, 1, 2);          // Taken to 21
        imem[19] = itype(OP_ADDI, 3, 0, 32'h99);
        imem[20] = itype(OP_ADDI, 3, 0, 32'h98);
        imem[21] = itype(OP_BNE, 2, 1, 5);          // Not taken
        imem[22] = itype(OP_ADDI, 4, 2, 6);
        imem[23] = itype(OP_BEQ, 1, 4, 3);          // Not taken
        imem[24] = itype(OP_BNE, 1, 4, 2);          // Taken to 27
        imem[25] = itype(OP_ADDI, 5, 0, 32'h55);
        imem[26] = itype(OP_ADDI, 5, 0, 32'h66);
        imem[27] = itype(OP_ADDI, 6, 4, 1);
        imem[28] = itype(OP_ADDI, 8, 0, 3);
        imem[29] = itype(OP_ADDI, 8, 8, -1);
        imem[30] = itype(OP_BNE, 0, 8, -2);         // Back to 29 until r8 is zero
        imem[31] = itype(OP_BEQ, 0, 0, -1);
        // Program C exercises register 0
        imem[32] = itype(OP_ADDI, 0, 0, 32'h123);
        imem[33] = rtype(FN_ADD, 1, 0, 0);
        imem[34] = itype(OP_ADDI, 2, 0, 32'h44);
        imem[35] = rtype(FN_ADD, 0, 2, 2);
        imem[36] = rtype(FN_OR,  3, 0, 2);          // r0 must not pick up 0x88
        imem[37] = itype(OP_ADDI, 4, 0, -1);
        imem[38] = itype(OP_BEQ, 1, 0, 1);          // Taken to 40 since r1 is zero
        imem[39] = itype(OP_ADDI, 5, 0, 1);
        imem[40] = itype(OP_ADDI, 5, 0, 2);
        imem[41] = itype(OP_BEQ, 0, 0, -1);
    endtask

    task automatic load_tables();
        exp_tab[0]  = '{4'd1,  32'h0000_0005};
        exp_tab[1]  = '{4'd2,  32'h0000_0002};
        exp_tab[2]  = '{4'd3,  32'h0000_0007};
        exp_tab[3]  = '{4'd4,  32'hffff_fffb};      // 2 - 7
        exp_tab[4]  = '{4'd5,  32'h0000_0003};
        exp_tab[5]  = '{4'd6,  32'hffff_fffb};
        exp_tab[6]  = '{4'd7,  32'hffff_fffe};
        exp_tab[7]  = '{4'd8,  32'h0000_0001};      // -5 < 3 signed
        exp_tab[8]  = '{4'd9,  32'h0000_0000};
        exp_tab[9]  = '{4'd10, 32'h0000_8000};
        exp_tab[10] = '{4'd11, 32'h0000_0000};
        exp_tab[11] = '{4'd1,  32'h0000_0001};
        exp_tab[12] = '{4'd2,  32'h0000_0001};
        exp_tab[13] = '{4'd4,  32'h0000_0007};
        exp_tab[14] = '{4'd6,  32'h0000_0008};
        exp_tab[15] = '{4'd8,  32'h0000_0003};
        exp_tab[16] = '{4'd8,  32'h0000_0002};
        exp_tab[17] = '{4'd8,  32'h0000_0001};
        exp_tab[18] = '{4'd8,  32'h0000_0000};
        exp_tab[19] = '{4'd1,  32'h0000_0000};
        exp_tab[20] = '{4'd2,  32'h0000_0044};
        exp_tab[21] = '{4'd3,  32'h0000_0044};
        exp_tab[22] = '{4'd4,  32'hffff_ffff};
        exp_tab[23] = '{4'd5,  32'h0000_0002};
        // start, halt, stall %, idle %, first, count
        cases[0] = '{32'h10, 32'h3c, 0,  0,  0,  11};
        cases[1] = '{32'h40, 32'h7c, 0,  0,  11, 8};
        cases[2] = '{32'h80, 32'ha4, 0,  0,  19, 5};
        cases[3] = '{32'h10, 32'h3c, 30, 25, 0,  11};
        cases[4] = '{32'h40, 32'h7c, 25, 30, 11, 8};
        cases[5] = '{32'h80, 32'ha4, 20, 20, 19, 5};
    endtask

    // Random back-pressure unless quiet
    initial begin
        void'($urandom(SEED));
        forever begin
            @(posedge clk);
            if (rst || quiet) begin
                stall    <= 1'b0;
                data_rdy <= 1'b1;
            end else begin
                stall    <= ($urandom % 100) < stall_pct;
                data_rdy <= ($urandom % 100) >= idle_pct;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        a_timeout: assert (cycles <= limit) else
            fail_run($sformatf("timeout: run not finished within %0d cycles", limit));
    end

    // Commit monitor sampled mid-cycle
    always @(negedge clk) begin
        if (!rst) begin
            a_retired: assert (retired == WORD_W'(seen)) else
                report_mismatch("retired", WORD_W'(seen), retired);
            if (wb.valid) begin
                a_expected: assert (seen < allowed) else
                    fail_run($sformatf("unexpected commit to r%0d at %0t", wb.rd, $time));
                a_rd: assert (wb.rd == order[seen].rd) else
                    report_mismatch("wb.rd", WORD_W'(order[seen].rd), WORD_W'(wb.rd));
                a_data: assert (wb.data == order[seen].data) else
                    report_mismatch("wb.data", order[seen].data, wb.data);
                seen = seen + 1;
            end
        end
    end

    task automatic run_case(input case_t tc);
        quiet  <= 1'b1;
        @(posedge clk);
        allowed = allowed + int'(tc.count);
        flush  <= 1'b1;                             // Stall already low here
        new_pc <= tc.start;
        @(posedge clk);
        flush     <= 1'b0;
        quiet     <= 1'b0;
        stall_pct <= tc.stall_pct;
        idle_pct  <= tc.idle_pct;
        while (seen < allowed) begin
            @(posedge clk);
        end
        while (fetch_addr - tc.halt > 32'd8) begin
            @(negedge clk);
        end
        repeat (HALT_CHECK) begin
            @(negedge clk);
            a_halt: assert (fetch_addr - tc.halt <= 32'd8) else
                fail_run($sformatf("fetch left the halt loop at %h, address %h",
                                   tc.halt, fetch_addr));
        end
    endtask

    initial begin
        int pos;
        load_program();
        load_tables();
        pos = 0;
        for (int c = 0; c < CASE_N; c++) begin
            for (int k = 0; k < int'(cases[c].count); k++) begin
                order[pos] = exp_tab[int'(cases[c].first) + k];
                pos = pos + 1;
            end
        end
        limit = pos * 40 + 500;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        for (int c = 0; c < CASE_N; c++) begin
            run_case(cases[c]);
        end
        @(negedge clk);
        if (seen == allowed && retired == WORD_W'(seen)) begin
            $display("Test passed");
            $finish;
        end else begin
            fail_run($sformatf("run ended with %0d of %0d commits, retired %0d",
                               seen, allowed, retired));
        end
    end

endmodule

// File: verilog.f
hw/cpu_pkg.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/result_stage.sv
hw/cpu_core.sv
tb/cpu_core_tb.sv
